//--- rtl/ptw_pkg.sv
`default_nettype none

package ptw_pkg;

  // sv39 virtual address layout
  localparam int vaddr_width_c       = 39;
  localparam int page_idx_width_c    = 9;
  localparam int page_table_depth_c  = 3;
  localparam int page_offset_width_c = 12;

  // one page-table entry is a double word
  localparam int pte_width_c = 64;

  // level counter runs 2 down to 0
  localparam int level_width_c = 2;

  // privilege modes as seen by the walker
  localparam int priv_width_c = 2;
  localparam logic [priv_width_c-1:0] priv_u_c = 2'd0;
  localparam logic [priv_width_c-1:0] priv_s_c = 2'd1;

  // bit positions inside the 3-bit miss kind {instr, load, store}
  localparam int kind_instr_c = 2;
  localparam int kind_load_c  = 1;
  localparam int kind_store_c = 0;

  // memory keeps raw words, walker and checker look at fields
  typedef union packed {
    logic [pte_width_c-1:0] raw;
    struct packed {
      logic [9:0]  reserved;
      logic [43:0] ppn;
      logic [1:0]  rsw;
      logic        d;
      logic        a;
      logic        g;
      logic        u;
      logic        x;
      logic        w;
      logic        r;
      logic        v;
    } f;
  } sv39_pte_u;

endpackage

`default_nettype wire

//--- rtl/ptw_pte_check.sv
`timescale 1ns/100ps
`default_nettype none

module ptw_pte_check (
  input  ptw_pkg::sv39_pte_u                pte_i,
  input  logic [ptw_pkg::level_width_c-1:0] level_i,
  // {instr, load, store}, one hot during a walk
  input  logic [2:0]                        kind_i,
  input  logic [ptw_pkg::priv_width_c-1:0]  priv_mode_i,
  input  logic                              sum_i,
  input  logic                              mxr_i,
  output logic                              pte_leaf_o,
  output logic                              instr_fault_o,
  output logic                              load_fault_o,
  output logic                              store_fault_o
);
  import ptw_pkg::*;

  logic [page_table_depth_c-2:0] misaligned_field;
  logic                          is_instr;
  logic                          is_load;
  logic                          is_store;
  logic                          leaf;
  logic                          invalid;
  logic                          leaf_missing;
  logic                          misaligned;
  logic                          priv_fault;
  logic                          ad_fault;
  logic                          common_fault;
  logic                          no_x;
  logic                          no_r;
  logic                          no_w;

  assign is_instr = kind_i[kind_instr_c];
  assign is_load  = kind_i[kind_load_c];
  assign is_store = kind_i[kind_store_c];

  assign leaf = pte_i.f.r | pte_i.f.w | pte_i.f.x;

  // reserved encodings: not valid, or writable but not readable
  assign invalid = ~pte_i.f.v | (pte_i.f.w & ~pte_i.f.r);

  // pointer at the last level
  assign leaf_missing = (level_i == '0) & ~leaf;

  // a superpage must have zero ppn fields below its level
  for (genvar i = 0; i < page_table_depth_c - 1; i++) begin : g_misalign
    assign misaligned_field[i] = (level_i > i) &
                                 (|pte_i.f.ppn[i*page_idx_width_c +: page_idx_width_c]);
  end
  assign misaligned = leaf & (|misaligned_field);

  // S mode may touch U pages only for data and only with SUM
  assign priv_fault = leaf &
    ((pte_i.f.u & (priv_mode_i == priv_s_c) & (is_instr | ~sum_i)) |
     (~pte_i.f.u & (priv_mode_i == priv_u_c)));

  // A and D are not updated in hardware, a missing bit faults
  assign ad_fault = leaf & (~pte_i.f.a | (is_store & ~pte_i.f.d));

  assign common_fault = invalid | leaf_missing | misaligned | priv_fault | ad_fault;

  assign no_x = leaf & ~pte_i.f.x;
  // MXR makes execute-only pages readable
  assign no_r = leaf & ~(pte_i.f.r | (pte_i.f.x & mxr_i));
  assign no_w = leaf & ~pte_i.f.w;

  assign pte_leaf_o    = leaf;
  assign instr_fault_o = is_instr & (common_fault | no_x);
  assign load_fault_o  = is_load & (common_fault | no_r);
  assign store_fault_o = is_store & (common_fault | no_w);

endmodule

`default_nettype wire

//--- rtl/ptw_pte_mem.sv
`timescale 1ns/100ps
`default_nettype none

module ptw_pte_mem #(
  parameter int mem_addr_width_p = 10
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // walker read port
  input  logic                            mem_v_i,
  input  logic [mem_addr_width_p-1:0]     mem_addr_i,
  output logic                            mem_ready_o,
  output logic                            mem_hit_o,
  output ptw_pkg::sv39_pte_u              mem_data_o,
  // host write port, double word index
  input  logic                            pt_we_i,
  input  logic [mem_addr_width_p-1:0]     pt_waddr_i,
  input  logic [ptw_pkg::pte_width_c-1:0] pt_wdata_i
);
  import ptw_pkg::*;

  localparam int depth_lp = 2 ** mem_addr_width_p;

  logic [pte_width_c-1:0] mem_r [depth_lp];
  logic                   accept;
  logic                   rd_pend_r;
  sv39_pte_u              rd_data_r;

  // host writes own the array for the cycle
  assign mem_ready_o = ~pt_we_i;
  assign accept      = mem_v_i & mem_ready_o;

  always_ff @(posedge clk_i) begin
    if (pt_we_i) begin
      mem_r[pt_waddr_i] <= pt_wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_data_r.raw <= mem_r[mem_addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_pend_r <= 1'b0;
    end else begin
      rd_pend_r <= accept;
    end
  end

  // a write landing in the response cycle turns the answer into a miss
  assign mem_hit_o  = rd_pend_r & ~pt_we_i;
  assign mem_data_o = rd_data_r;

endmodule

`default_nettype wire

//--- rtl/ptw_walker.sv
`timescale 1ns/100ps
`default_nettype none

module ptw_walker #(
  parameter int ptag_width_p     = 20,
  parameter int mem_addr_width_p = 10
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  // miss request, held by the requester until the fill
  input  logic                                  miss_instr_i,
  input  logic                                  miss_load_i,
  input  logic                                  miss_store_i,
  input  logic [ptw_pkg::vaddr_width_c-1:0]     miss_vaddr_i,
  input  logic [ptw_pkg::priv_width_c-1:0]      priv_mode_i,
  input  logic                                  mstatus_sum_i,
  input  logic                                  mstatus_mxr_i,
  input  logic [ptag_width_p-1:0]               base_ppn_i,
  output logic                                  busy_o,
  // page-table memory
  output logic                                  mem_v_o,
  output logic [mem_addr_width_p-1:0]           mem_addr_o,
  input  logic                                  mem_ready_i,
  input  logic                                  mem_hit_i,
  input  ptw_pkg::sv39_pte_u                    mem_data_i,
  // entry checker
  output ptw_pkg::sv39_pte_u                    pte_o,
  output logic [ptw_pkg::level_width_c-1:0]     level_o,
  output logic [2:0]                            kind_o,
  output logic [ptw_pkg::priv_width_c-1:0]      priv_mode_o,
  output logic                                  sum_o,
  output logic                                  mxr_o,
  input  logic                                  pte_leaf_i,
  input  logic                                  instr_fault_i,
  input  logic                                  load_fault_i,
  input  logic                                  store_fault_i,
  // fill packet
  output logic                                  fill_v_o,
  output logic                                  fill_itlb_o,
  output logic                                  fill_dtlb_o,
  output logic                                  instr_fault_o,
  output logic                                  load_fault_o,
  output logic                                  store_fault_o,
  output logic [ptw_pkg::vaddr_width_c-1:0]     fill_vaddr_o,
  output logic [ptag_width_p-1:0]               fill_ptag_o,
  output logic                                  fill_gigapage_o,
  output logic [7:0]                            fill_flags_o
);
  import ptw_pkg::*;

  localparam int vpn_width_lp     = page_idx_width_c * page_table_depth_c;
  localparam int low_ppn_width_lp = page_idx_width_c * (page_table_depth_c - 1);
  localparam int tbl_bits_lp      = mem_addr_width_p - page_idx_width_c;
  localparam logic [level_width_c-1:0] top_level_lp = level_width_c'(page_table_depth_c - 1);

  localparam logic [2:0] st_idle_lp  = 3'd0;
  localparam logic [2:0] st_send_lp  = 3'd1;
  localparam logic [2:0] st_recv_lp  = 3'd2;
  localparam logic [2:0] st_check_lp = 3'd3;
  localparam logic [2:0] st_write_lp = 3'd4;

  logic [2:0]                   state_r;
  logic [2:0]                   state_n;
  logic                         is_idle;
  logic                         is_send;
  logic                         is_recv;
  logic                         is_check;
  logic                         is_write;
  logic                         any_miss;
  logic                         capture;
  logic                         req_pend_r;
  logic                         descend;
  logic                         page_fault;
  logic [2:0]                   kind_r;
  logic [vaddr_width_c-1:0]     vaddr_r;
  logic [priv_width_c-1:0]      priv_r;
  logic                         sum_r;
  logic                         mxr_r;
  logic [level_width_c-1:0]     level_r;
  logic [ptag_width_p-1:0]      ppn_r;
  sv39_pte_u                    pte_r;
  logic [vpn_width_lp-1:0]      vpn;
  logic [page_idx_width_c-1:0]  vpn_field;
  logic [ptag_width_p-1:0]      wb_ptag;

  assign is_idle  = (state_r == st_idle_lp);
  assign is_send  = (state_r == st_send_lp);
  assign is_recv  = (state_r == st_recv_lp);
  assign is_check = (state_r == st_check_lp);
  assign is_write = (state_r == st_write_lp);

  assign any_miss = miss_instr_i | miss_load_i | miss_store_i;
  // request is registered in the miss cycle, the walk leaves idle the cycle after
  assign capture  = is_idle & ~req_pend_r & any_miss;

  assign page_fault = instr_fault_i | load_fault_i | store_fault_i;
  assign descend    = is_check & ~pte_leaf_i & ~page_fault;

  always_comb begin
    case (state_r)
      st_idle_lp:  state_n = req_pend_r ? st_send_lp : st_idle_lp;
      st_send_lp:  state_n = (mem_v_o & mem_ready_i) ? st_recv_lp : st_send_lp;
      // no hit means the same load goes out again
      st_recv_lp:  state_n = mem_hit_i ? st_check_lp : st_send_lp;
      st_check_lp: state_n = (pte_leaf_i | page_fault) ? st_write_lp : st_send_lp;
      default:     state_n = st_idle_lp;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= st_idle_lp;
      req_pend_r <= 1'b0;
      kind_r     <= '0;
      level_r    <= top_level_lp;
    end else begin
      state_r    <= state_n;
      req_pend_r <= capture;
      if (capture) begin
        kind_r  <= {miss_instr_i, miss_load_i, miss_store_i};
        level_r <= top_level_lp;
      end else if (descend) begin
        level_r <= level_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      vaddr_r <= miss_vaddr_i;
      priv_r  <= priv_mode_i;
      sum_r   <= mstatus_sum_i;
      mxr_r   <= mstatus_mxr_i;
      ppn_r   <= base_ppn_i;
    end else if (is_check) begin
      // next table on a pointer, leaf ppn otherwise
      ppn_r <= pte_r.f.ppn[ptag_width_p-1:0];
    end
    if (is_recv & mem_hit_i) begin
      pte_r <= mem_data_i;
    end
  end

  assign vpn       = vaddr_r[vaddr_width_c-1:page_offset_width_c];
  assign vpn_field = vpn[level_r*page_idx_width_c +: page_idx_width_c];

  assign mem_v_o    = is_send;
  assign mem_addr_o = {ppn_r[tbl_bits_lp-1:0], vpn_field};

  // superpages take the low ppn fields from the vpn
  for (genvar i = 0; i < page_table_depth_c - 1; i++) begin : g_ptag
    assign wb_ptag[i*page_idx_width_c +: page_idx_width_c] =
      (level_r > i) ? vpn[i*page_idx_width_c +: page_idx_width_c]
                    : ppn_r[i*page_idx_width_c +: page_idx_width_c];
  end
  assign wb_ptag[ptag_width_p-1:low_ppn_width_lp] = ppn_r[ptag_width_p-1:low_ppn_width_lp];

  assign pte_o       = pte_r;
  assign level_o     = level_r;
  assign kind_o      = kind_r;
  assign priv_mode_o = priv_r;
  assign sum_o       = sum_r;
  assign mxr_o       = mxr_r;

  assign busy_o = ~is_idle;

  assign fill_v_o        = is_write;
  assign fill_itlb_o     = is_write & kind_r[kind_instr_c] & ~page_fault;
  assign fill_dtlb_o     = is_write & ~kind_r[kind_instr_c] & ~page_fault;
  assign instr_fault_o   = is_write & instr_fault_i;
  assign load_fault_o    = is_write & load_fault_i;
  assign store_fault_o   = is_write & store_fault_i;
  assign fill_vaddr_o    = vaddr_r;
  assign fill_ptag_o     = wb_ptag;
  assign fill_gigapage_o = is_write & (level_r == top_level_lp);
  assign fill_flags_o    = {pte_r.f.d, pte_r.f.a, pte_r.f.g, pte_r.f.u,
                            pte_r.f.x, pte_r.f.w, pte_r.f.r, pte_r.f.v};

endmodule

`default_nettype wire

//--- rtl/ptw_top.sv
`timescale 1ns/100ps
`default_nettype none

module ptw_top #(
  parameter int ptag_width_p     = 20,
  parameter int mem_addr_width_p = 10
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              miss_instr_i,
  input  logic                              miss_load_i,
  input  logic                              miss_store_i,
  input  logic [ptw_pkg::vaddr_width_c-1:0] miss_vaddr_i,
  input  logic [ptw_pkg::priv_width_c-1:0]  priv_mode_i,
  input  logic                              mstatus_sum_i,
  input  logic                              mstatus_mxr_i,
  input  logic [ptag_width_p-1:0]           base_ppn_i,
  input  logic                              pt_we_i,
  input  logic [mem_addr_width_p-1:0]       pt_waddr_i,
  input  logic [ptw_pkg::pte_width_c-1:0]   pt_wdata_i,
  output logic                              busy_o,
  output logic                              fill_v_o,
  output logic                              fill_itlb_o,
  output logic                              fill_dtlb_o,
  output logic                              instr_fault_o,
  output logic                              load_fault_o,
  output logic                              store_fault_o,
  output logic [ptw_pkg::vaddr_width_c-1:0] fill_vaddr_o,
  output logic [ptag_width_p-1:0]           fill_ptag_o,
  output logic                              fill_gigapage_o,
  output logic [7:0]                        fill_flags_o
);
  import ptw_pkg::*;

  logic                        mem_v;
  logic                        mem_ready;
  logic [mem_addr_width_p-1:0] mem_addr;
  logic                        mem_hit;
  sv39_pte_u                   mem_data;
  sv39_pte_u                   pte;
  logic [level_width_c-1:0]    level;
  logic [2:0]                  kind;
  logic [priv_width_c-1:0]     priv_mode;
  logic                        sum;
  logic                        mxr;
  logic                        pte_leaf;
  logic                        chk_instr_fault;
  logic                        chk_load_fault;
  logic                        chk_store_fault;

  ptw_walker #(
    .ptag_width_p     (ptag_width_p),
    .mem_addr_width_p (mem_addr_width_p)
  ) i_walker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_instr_i    (miss_instr_i),
    .miss_load_i     (miss_load_i),
    .miss_store_i    (miss_store_i),
    .miss_vaddr_i    (miss_vaddr_i),
    .priv_mode_i     (priv_mode_i),
    .mstatus_sum_i   (mstatus_sum_i),
    .mstatus_mxr_i   (mstatus_mxr_i),
    .base_ppn_i      (base_ppn_i),
    .busy_o          (busy_o),
    .mem_v_o         (mem_v),
    .mem_addr_o      (mem_addr),
    .mem_ready_i     (mem_ready),
    .mem_hit_i       (mem_hit),
    .mem_data_i      (mem_data),
    .pte_o           (pte),
    .level_o         (level),
    .kind_o          (kind),
    .priv_mode_o     (priv_mode),
    .sum_o           (sum),
    .mxr_o           (mxr),
    .pte_leaf_i      (pte_leaf),
    .instr_fault_i   (chk_instr_fault),
    .load_fault_i    (chk_load_fault),
    .store_fault_i   (chk_store_fault),
    .fill_v_o        (fill_v_o),
    .fill_itlb_o     (fill_itlb_o),
    .fill_dtlb_o     (fill_dtlb_o),
    .instr_fault_o   (instr_fault_o),
    .load_fault_o    (load_fault_o),
    .store_fault_o   (store_fault_o),
    .fill_vaddr_o    (fill_vaddr_o),
    .fill_ptag_o     (fill_ptag_o),
    .fill_gigapage_o (fill_gigapage_o),
    .fill_flags_o    (fill_flags_o)
  );

  ptw_pte_check i_check (
    .pte_i         (pte),
    .level_i       (level),
    .kind_i        (kind),
    .priv_mode_i   (priv_mode),
    .sum_i         (sum),
    .mxr_i         (mxr),
    .pte_leaf_o    (pte_leaf),
    .instr_fault_o (chk_instr_fault),
    .load_fault_o  (chk_load_fault),
    .store_fault_o (chk_store_fault)
  );

  ptw_pte_mem #(
    .mem_addr_width_p (mem_addr_width_p)
  ) i_mem (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mem_v_i     (mem_v),
    .mem_addr_i  (mem_addr),
    .mem_ready_o (mem_ready),
    .mem_hit_o   (mem_hit),
    .mem_data_o  (mem_data),
    .pt_we_i     (pt_we_i),
    .pt_waddr_i  (pt_waddr_i),
    .pt_wdata_i  (pt_wdata_i)
  );

endmodule

`default_nettype wire

//--- tests/ptw_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module ptw_clk_gen #(
  parameter int period_p       = 20,
  parameter int reset_cycles_p = 10
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // reset drops just after an edge, like any other driven input
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    #2;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- tests/ptw_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ptw_tb;
  import ptw_pkg::*;

  localparam int ptag_width_p     = 20;
  localparam int mem_addr_width_p = 10;
  localparam int num_rows_c       = 20;
  localparam int timeout_c        = 2000 + 40 * num_rows_c;

  // miss kinds as {instr, load, store}
  localparam logic [2:0] if_c = 3'b100;
  localparam logic [2:0] ld_c = 3'b010;
  localparam logic [2:0] st_c = 3'b001;

  // root table sits in the upper half of the memory (odd ppn)
  localparam logic [mem_addr_width_p-1:0] root_c = 10'h200;

  typedef struct packed {
    logic [vaddr_width_c-1:0] vaddr;
    logic [2:0]               kind;
    logic [priv_width_c-1:0]  priv;
    logic [1:0]               sum_mxr;
    logic                     fault;
    logic [ptag_width_p-1:0]  ptag;
    logic                     giga;
    logic [7:0]               flags;
    logic [1:0]               level;
  } row_t;

  logic                        clk_i;
  logic                        reset_i;
  logic                        miss_instr_i;
  logic                        miss_load_i;
  logic                        miss_store_i;
  logic [vaddr_width_c-1:0]    miss_vaddr_i;
  logic [priv_width_c-1:0]     priv_mode_i;
  logic                        mstatus_sum_i;
  logic                        mstatus_mxr_i;
  logic [ptag_width_p-1:0]     base_ppn_i;
  logic                        pt_we_i;
  logic [mem_addr_width_p-1:0] pt_waddr_i;
  logic [pte_width_c-1:0]      pt_wdata_i;
  logic                        busy_o;
  logic                        fill_v_o;
  logic                        fill_itlb_o;
  logic                        fill_dtlb_o;
  logic                        instr_fault_o;
  logic                        load_fault_o;
  logic                        store_fault_o;
  logic [vaddr_width_c-1:0]    fill_vaddr_o;
  logic [ptag_width_p-1:0]     fill_ptag_o;
  logic                        fill_gigapage_o;
  logic [7:0]                  fill_flags_o;

  row_t        rows [num_rows_c];
  int          row_cnt   = 0;
  int          error_cnt = 0;
  int          check_cnt = 0;
  int          cycle_cnt = 0;

  ptw_clk_gen #(.period_p(20), .reset_cycles_p(10)) i_clk_gen (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  ptw_top #(
    .ptag_width_p     (ptag_width_p),
    .mem_addr_width_p (mem_addr_width_p)
  ) i_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_instr_i    (miss_instr_i),
    .miss_load_i     (miss_load_i),
    .miss_store_i    (miss_store_i),
    .miss_vaddr_i    (miss_vaddr_i),
    .priv_mode_i     (priv_mode_i),
    .mstatus_sum_i   (mstatus_sum_i),
    .mstatus_mxr_i   (mstatus_mxr_i),
    .base_ppn_i      (base_ppn_i),
    .pt_we_i         (pt_we_i),
    .pt_waddr_i      (pt_waddr_i),
    .pt_wdata_i      (pt_wdata_i),
    .busy_o          (busy_o),
    .fill_v_o        (fill_v_o),
    .fill_itlb_o     (fill_itlb_o),
    .fill_dtlb_o     (fill_dtlb_o),
    .instr_fault_o   (instr_fault_o),
    .load_fault_o    (load_fault_o),
    .store_fault_o   (store_fault_o),
    .fill_vaddr_o    (fill_vaddr_o),
    .fill_ptag_o     (fill_ptag_o),
    .fill_gigapage_o (fill_gigapage_o),
    .fill_flags_o    (fill_flags_o)
  );

  function automatic logic [pte_width_c-1:0] make_pte(input logic [43:0] ppn,
                                                      input logic [7:0] flags);
    return {10'b0, ppn, 2'b0, flags};
  endfunction

  function automatic logic [vaddr_width_c-1:0] to_vaddr(input int vpn2, input int vpn1,
                                                        input int vpn0);
    return {9'(vpn2), 9'(vpn1), 9'(vpn0), 12'h0a8};
  endfunction

  task automatic check_ptag(input logic [ptag_width_p-1:0] act,
                            input logic [ptag_width_p-1:0] exp, input string name);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_flags(input logic [7:0] act, input logic [7:0] exp, input string name);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string name);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("[ERROR] %0t %s: got %b expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_vaddr(input logic [vaddr_width_c-1:0] act,
                             input logic [vaddr_width_c-1:0] exp, input string name);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_latency(input int act, input int exp);
    check_cnt++;
    if (act != exp) begin
      error_cnt++;
      $display("[ERROR] %0t fill_v_o latency: got %0d cycles expected %0d", $time, act, exp);
    end
  endtask

  task automatic write_word(input logic [mem_addr_width_p-1:0] addr,
                            input logic [pte_width_c-1:0] data);
    pt_we_i    = 1'b1;
    pt_waddr_i = addr;
    pt_wdata_i = data;
    @(posedge clk_i);
    #2;
    pt_we_i = 1'b0;
  endtask

  task automatic build_tables();
    // root table indexed by vpn2
    write_word(root_c + 10'd0, make_pte(44'h2, 8'h01));
    write_word(root_c + 10'd1, make_pte(44'h40000, 8'hcf));
    write_word(root_c + 10'd2, make_pte(44'h40200, 8'hcf));
    write_word(root_c + 10'd4, make_pte(44'h0, 8'h00));
    write_word(root_c + 10'd5, make_pte(44'h0, 8'hc5));
    write_word(root_c + 10'd6, make_pte(44'h80000, 8'hd7));
    // level 1 pointer and megapage in the lower half
    write_word(10'd0, make_pte(44'h3, 8'h01));
    write_word(10'd1, make_pte(44'h00a00, 8'hcb));
    // level 0 shares the upper half above the root slots
    write_word(root_c + 10'd16, make_pte(44'h12345, 8'hc7));
    write_word(root_c + 10'd17, make_pte(44'h23456, 8'hc9));
    write_word(root_c + 10'd18, make_pte(44'h34567, 8'hdf));
    write_word(root_c + 10'd19, make_pte(44'h45678, 8'h47));
    write_word(root_c + 10'd20, make_pte(44'h1, 8'h01));
  endtask

  task automatic add_row(input logic [vaddr_width_c-1:0] vaddr, input logic [2:0] kind,
                         input logic [priv_width_c-1:0] priv, input logic [1:0] sum_mxr,
                         input logic fault, input logic [ptag_width_p-1:0] ptag,
                         input logic giga, input logic [7:0] flags, input logic [1:0] level);
    rows[row_cnt] = {vaddr, kind, priv, sum_mxr, fault, ptag, giga, flags, level};
    row_cnt++;
  endtask

  task automatic fill_rows();
    // 4 KiB leaves three levels deep
    add_row(to_vaddr(0, 0, 16), ld_c, priv_s_c, 2'b00, 1'b0, 20'h12345, 1'b0, 8'hc7, 2'd0);
    add_row(to_vaddr(0, 0, 16), st_c, priv_s_c, 2'b00, 1'b0, 20'h12345, 1'b0, 8'hc7, 2'd0);
    add_row(to_vaddr(0, 0, 17), if_c, priv_s_c, 2'b00, 1'b0, 20'h23456, 1'b0, 8'hc9, 2'd0);
    add_row(to_vaddr(0, 0, 16), if_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd0);
    // superpages
    add_row(to_vaddr(0, 1, 5), ld_c, priv_s_c, 2'b00, 1'b0, {11'h005, 9'd5}, 1'b0, 8'hcb, 2'd1);
    add_row(to_vaddr(1, 51, 68), ld_c, priv_s_c, 2'b00, 1'b0, {2'b01, 9'd51, 9'd68}, 1'b1,
            8'hcf, 2'd2);
    // structural faults
    add_row(to_vaddr(2, 0, 0), ld_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd2);
    add_row(to_vaddr(4, 0, 0), ld_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd2);
    add_row(to_vaddr(5, 0, 0), st_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd2);
    add_row(to_vaddr(0, 0, 20), ld_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd0);
    // privilege, sum and mxr
    add_row(to_vaddr(0, 0, 18), ld_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd0);
    add_row(to_vaddr(0, 0, 18), ld_c, priv_s_c, 2'b10, 1'b0, 20'h34567, 1'b0, 8'hdf, 2'd0);
    add_row(to_vaddr(0, 0, 18), if_c, priv_s_c, 2'b10, 1'b1, 20'h0, 1'b0, 8'h00, 2'd0);
    add_row(to_vaddr(0, 0, 16), ld_c, priv_u_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd0);
    add_row(to_vaddr(0, 0, 18), ld_c, priv_u_c, 2'b00, 1'b0, 20'h34567, 1'b0, 8'hdf, 2'd0);
    add_row(to_vaddr(0, 0, 17), ld_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd0);
    add_row(to_vaddr(0, 0, 17), ld_c, priv_s_c, 2'b01, 1'b0, 20'h23456, 1'b0, 8'hc9, 2'd0);
    add_row(to_vaddr(0, 0, 19), st_c, priv_s_c, 2'b00, 1'b1, 20'h0, 1'b0, 8'h00, 2'd0);
    add_row(to_vaddr(0, 0, 19), ld_c, priv_s_c, 2'b00, 1'b0, 20'h45678, 1'b0, 8'h47, 2'd0);
    add_row(to_vaddr(6, 7, 8), st_c, priv_u_c, 2'b00, 1'b0, {2'b10, 9'd7, 9'd8}, 1'b1,
            8'hd7, 2'd2);
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   cycles;
    int   wr_cycle;
    logic got_fill;
    r        = rows[idx];
    wr_cycle = 0;
    // odd rows see one host write to an unused word at a random cycle
    if (idx % 2 == 1) begin
      wr_cycle = 1 + int'($urandom % 9);
    end
    miss_instr_i  = r.kind[2];
    miss_load_i   = r.kind[1];
    miss_store_i  = r.kind[0];
    miss_vaddr_i  = r.vaddr;
    priv_mode_i   = r.priv;
    mstatus_sum_i = r.sum_mxr[1];
    mstatus_mxr_i = r.sum_mxr[0];
    cycles   = 0;
    got_fill = 1'b0;
    while (!got_fill) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (fill_v_o) begin
        got_fill = 1'b1;
      end else begin
        if (cycles >= 2) begin
          check_bit(busy_o, 1'b1, "busy_o");
        end
        #1;
        pt_we_i    = (cycles == wr_cycle);
        pt_waddr_i = 10'(256 + idx);
        pt_wdata_i = {32'h0bad_cafe, 22'h0, pt_waddr_i};
      end
    end
    check_bit(busy_o, 1'b1, "busy_o");
    check_bit(fill_itlb_o, ~r.fault & r.kind[2], "fill_itlb_o");
    check_bit(fill_dtlb_o, ~r.fault & ~r.kind[2], "fill_dtlb_o");
    check_bit(instr_fault_o, r.fault & r.kind[2], "instr_fault_o");
    check_bit(load_fault_o, r.fault & r.kind[1], "load_fault_o");
    check_bit(store_fault_o, r.fault & r.kind[0], "store_fault_o");
    check_vaddr(fill_vaddr_o, r.vaddr, "fill_vaddr_o");
    if (!r.fault) begin
      check_ptag(fill_ptag_o, r.ptag, "fill_ptag_o");
      check_bit(fill_gigapage_o, r.giga, "fill_gigapage_o");
      check_flags(fill_flags_o, r.flags, "fill_flags_o");
    end
    if (wr_cycle == 0) begin
      check_latency(cycles, 2 + 3 * (3 - int'(r.level)));
    end
    #1;
    miss_instr_i = 1'b0;
    miss_load_i  = 1'b0;
    miss_store_i = 1'b0;
    pt_we_i      = 1'b0;
    @(posedge clk_i);
    #1;
    check_bit(busy_o, 1'b0, "busy_o");
    check_bit(fill_v_o, 1'b0, "fill_v_o");
    #1;
  endtask

  // bound on the whole run
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_c) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_c);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    miss_instr_i  = 1'b0;
    miss_load_i   = 1'b0;
    miss_store_i  = 1'b0;
    miss_vaddr_i  = '0;
    priv_mode_i   = priv_s_c;
    mstatus_sum_i = 1'b0;
    mstatus_mxr_i = 1'b0;
    base_ppn_i    = 20'd1;
    pt_we_i       = 1'b0;
    pt_waddr_i    = '0;
    pt_wdata_i    = '0;
    void'($urandom(32'hafb4_fec4));
    fill_rows();
    wait (reset_i == 1'b0);
    // idle outputs straight after reset
    check_bit(busy_o, 1'b0, "busy_o");
    check_bit(fill_v_o, 1'b0, "fill_v_o");
    check_bit(fill_itlb_o, 1'b0, "fill_itlb_o");
    check_bit(fill_dtlb_o, 1'b0, "fill_dtlb_o");
    check_bit(instr_fault_o, 1'b0, "instr_fault_o");
    check_bit(load_fault_o, 1'b0, "load_fault_o");
    check_bit(store_fault_o, 1'b0, "store_fault_o");
    build_tables();
    for (int i = 0; i < row_cnt; i++) begin
      run_row(i);
    end
    $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
rtl/ptw_pkg.sv
rtl/ptw_pte_check.sv
rtl/ptw_pte_mem.sv
rtl/ptw_walker.sv
rtl/ptw_top.sv
tests/ptw_clk_gen.sv
tests/ptw_tb.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module ptw_tb -f files.f -o ptw_sim > sim.log 2>&1 \
  && ./obj_dir/ptw_sim >> sim.log 2>&1 \
  || { cat sim.log; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
